// File: src/video_capture_pkg.sv
package video_capture_pkg;

    ////////////////////////////////////////////////////////////////////
    // camera ports and data widths
    ////////////////////////////////////////////////////////////////////
    localparam int NUM_CAMS = 2;                      // camera ports on the board

    typedef logic [0:0]  cam_idx_t;                   // picks one camera
    typedef logic [7:0]  cam_byte_t;                  // raw byte from the sensor bus
    typedef logic [15:0] rgb565_t;                    // two bytes joined into one pixel
    typedef logic [7:0]  chan8_t;                     // padded output colour channel

    ////////////////////////////////////////////////////////////////////
    // power-up sequencing
    ////////////////////////////////////////////////////////////////////
    localparam int POWER_STEP = 16;                   // cycles between camera releases
    localparam int SEQ_LAST   = POWER_STEP * NUM_CAMS; // step count where the last one goes

    typedef logic [$clog2(SEQ_LAST + 1)-1:0] seq_cnt_t; // holds 0 to SEQ_LAST

    ////////////////////////////////////////////////////////////////////
    // heartbeat
    ////////////////////////////////////////////////////////////////////
    typedef logic [6:0] heartbeat_cnt_t;              // 0 to HEARTBEAT_TICKS

    localparam heartbeat_cnt_t HEARTBEAT_TICKS = 7'd64; // wrap point, 65 cycles a period

    ////////////////////////////////////////////////////////////////////
    // byte pairing FSM
    ////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        PACK_IDLE = 2'd0,                             // waiting for the first byte
        PACK_HIGH = 2'd1,                             // high byte held
        PACK_OUT  = 2'd2                              // pixel word valid this cycle
    } pack_state_t;

endpackage

// File: src/cam_power_seq.sv
module cam_power_seq (
    input  logic                                    core_clk,
    input  logic                                    rst_n_i,
    output logic [video_capture_pkg::NUM_CAMS-1:0]  cam_en_o   // camera reset release
);

    video_capture_pkg::seq_cnt_t                step_cnt;      // cycles since reset left
    logic [video_capture_pkg::NUM_CAMS-1:0]     cam_en_q;      // release per camera

    // counter stops at the last release point
    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            step_cnt <= '0;
        end
        else if (step_cnt != video_capture_pkg::seq_cnt_t'(video_capture_pkg::SEQ_LAST))
        begin
            step_cnt <= step_cnt + 1'b1;                       // keep counting
        end
    end

    // camera k goes free after POWER_STEP*(k+1) edges out of reset
    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            cam_en_q <= '0;                                    // all cameras held
        end
        else
        begin
            for (int k = 0; k < video_capture_pkg::NUM_CAMS; k++)
            begin
                cam_en_q[k] <= (step_cnt >= video_capture_pkg::seq_cnt_t'(
                    video_capture_pkg::POWER_STEP * (k + 1) - 1)); // held by the stopped counter
            end
        end
    end

    assign cam_en_o = cam_en_q;

    // the packers rely on an enable that only ever rises
    a_en_sticky : assert property (
        @(posedge core_clk) disable iff (!rst_n_i)
        1'b1 |=> ((cam_en_o & $past(cam_en_o)) == $past(cam_en_o))
    )
    else $error("camera enable dropped after release");

endmodule

// File: src/cmos_pixel_packer.sv
module cmos_pixel_packer (
    input  logic                           core_clk,
    input  logic                           rst_n_i,
    input  logic                           cam_en_i,    // from power sequencer
    input  logic                           vsync_i,     // frame sync from sensor
    input  logic                           href_i,      // line valid from sensor
    input  video_capture_pkg::cam_byte_t   data_i,      // sensor byte
    output video_capture_pkg::rgb565_t     pix_data_o,  // joined pixel
    output logic                           pix_de_o,    // one cycle per pixel
    output logic                           pix_vs_o     // vsync, aligned with data
);

    logic                            vsync_d;     // input stage
    logic                            href_d;
    video_capture_pkg::cam_byte_t    data_d;
    video_capture_pkg::cam_byte_t    hi_byte;     // first byte of the pair
    video_capture_pkg::rgb565_t      pix_word;    // joined word
    video_capture_pkg::pack_state_t  state;
    logic                            vs_q;        // second vsync stage

    ////////////////////////////////////////////////////////////////////
    // input register
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            vsync_d <= 1'b0;
            href_d  <= 1'b0;
        end
        else
        begin
            vsync_d <= vsync_i;
            href_d  <= href_i;
        end
    end

    always_ff @(posedge core_clk)
    begin
        data_d <= data_i;                                  // raw byte, no reset
    end

    ////////////////////////////////////////////////////////////////////
    // byte pairing
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            state <= video_capture_pkg::PACK_IDLE;
        end
        else if (!cam_en_i || !href_d)
        begin
            state <= video_capture_pkg::PACK_IDLE;         // line end drops an odd byte
        end
        else
        begin
            unique case (state)
                video_capture_pkg::PACK_IDLE: state <= video_capture_pkg::PACK_HIGH;
                video_capture_pkg::PACK_HIGH: state <= video_capture_pkg::PACK_OUT;
                video_capture_pkg::PACK_OUT:  state <= video_capture_pkg::PACK_HIGH;
                default:                      state <= video_capture_pkg::PACK_IDLE;
            endcase
        end
    end

    // payload follows the state, held in plain registers
    always_ff @(posedge core_clk)
    begin
        if (href_d && state != video_capture_pkg::PACK_HIGH)
        begin
            hi_byte <= data_d;                             // start of a new pair
        end
        if (href_d && state == video_capture_pkg::PACK_HIGH)
        begin
            pix_word <= {hi_byte, data_d};                 // high byte first
        end
    end

    // vsync takes the same two stages as the data
    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            vs_q <= 1'b0;
        end
        else
        begin
            vs_q <= vsync_d;
        end
    end

    assign pix_data_o = pix_word;
    assign pix_de_o   = (state == video_capture_pkg::PACK_OUT);
    assign pix_vs_o   = vs_q;

    // a camera still in reset must never show a pixel
    a_de_gated : assert property (
        @(posedge core_clk) disable iff (!rst_n_i)
        !cam_en_i |-> !pix_de_o
    )
    else $error("pixel valid while camera disabled");

endmodule

// File: src/video_out_select.sv
module video_out_select (
    input  logic                                                 core_clk,
    input  logic                                                 rst_n_i,
    input  video_capture_pkg::cam_idx_t                          src_sel_i,  // camera shown
    input  video_capture_pkg::rgb565_t [video_capture_pkg::NUM_CAMS-1:0] pix_data_i,
    input  logic [video_capture_pkg::NUM_CAMS-1:0]               pix_de_i,
    input  logic [video_capture_pkg::NUM_CAMS-1:0]               pix_vs_i,
    output logic                                                 vs_o,
    output logic                                                 de_o,
    output video_capture_pkg::chan8_t                            r_o,
    output video_capture_pkg::chan8_t                            g_o,
    output video_capture_pkg::chan8_t                            b_o
);

    video_capture_pkg::rgb565_t  sel_word;    // word of the chosen camera
    logic                        sel_de;
    logic                        sel_vs;

    ////////////////////////////////////////////////////////////////////
    // source mux
    ////////////////////////////////////////////////////////////////////
    assign sel_word = pix_data_i[src_sel_i];
    assign sel_de   = pix_de_i[src_sel_i];
    assign sel_vs   = pix_vs_i[src_sel_i];

    ////////////////////////////////////////////////////////////////////
    // field swap, zero pad, output register
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            vs_o <= 1'b0;
            de_o <= 1'b0;
            r_o  <= '0;
            g_o  <= '0;
            b_o  <= '0;
        end
        else
        begin
            vs_o <= sel_vs;
            de_o <= sel_de;
            r_o  <= {sel_word[4:0],   3'b000};             // low field goes to red
            g_o  <= {sel_word[10:5],  2'b00};              // green stays in the middle
            b_o  <= {sel_word[15:11], 3'b000};             // high field goes to blue
        end
    end

    // the select must name a camera that exists
    a_sel_range : assert property (
        @(posedge core_clk) disable iff (!rst_n_i)
        int'(src_sel_i) < video_capture_pkg::NUM_CAMS
    )
    else $error("source select out of range");

endmodule

// File: src/heartbeat_led.sv
module heartbeat_led (
    input  logic  core_clk,
    input  logic  rst_n_i,
    output logic  heart_beat_o    // board LED
);

    video_capture_pkg::heartbeat_cnt_t  beat_cnt;   // cycles in the current half period
    logic                               wrap;       // last count of the half period

    assign wrap = (beat_cnt == video_capture_pkg::HEARTBEAT_TICKS);

    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            beat_cnt <= '0;
        end
        else if (wrap)
        begin
            beat_cnt <= '0;                                // start next half period
        end
        else
        begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // LED comes out of reset lit
    always_ff @(posedge core_clk)
    begin
        if (!rst_n_i)
        begin
            heart_beat_o <= 1'b1;
        end
        else if (wrap)
        begin
            heart_beat_o <= ~heart_beat_o;                 // flip once per wrap
        end
    end

endmodule

// File: src/video_capture_top.sv
module video_capture_top (
    input  logic                                                  core_clk,
    input  logic                                                  rst_n_i,
    input  logic [video_capture_pkg::NUM_CAMS-1:0]                cam_vsync_i,
    input  logic [video_capture_pkg::NUM_CAMS-1:0]                cam_href_i,
    input  video_capture_pkg::cam_byte_t [video_capture_pkg::NUM_CAMS-1:0] cam_data_i,
    input  video_capture_pkg::cam_idx_t                           src_sel_i,
    output logic [video_capture_pkg::NUM_CAMS-1:0]                cam_rstn_o,
    output logic                                                  vs_o,
    output logic                                                  de_o,
    output video_capture_pkg::chan8_t                             r_o,
    output video_capture_pkg::chan8_t                             g_o,
    output video_capture_pkg::chan8_t                             b_o,
    output logic                                                  heart_beat_o
);

    logic [video_capture_pkg::NUM_CAMS-1:0]                      cam_en;   // per camera release
    video_capture_pkg::rgb565_t [video_capture_pkg::NUM_CAMS-1:0] pix_data; // packer words
    logic [video_capture_pkg::NUM_CAMS-1:0]                      pix_de;
    logic [video_capture_pkg::NUM_CAMS-1:0]                      pix_vs;

    ////////////////////////////////////////////////////////////////////
    // camera power-up
    ////////////////////////////////////////////////////////////////////
    cam_power_seq u_power_seq (
        .core_clk (core_clk),
        .rst_n_i  (rst_n_i),
        .cam_en_o (cam_en)
    );

    assign cam_rstn_o = cam_en;                          // same bits drive the sensor resets

    ////////////////////////////////////////////////////////////////////
    // one packer per camera
    ////////////////////////////////////////////////////////////////////
    for (genvar k = 0; k < video_capture_pkg::NUM_CAMS; k++)
    begin : g_cam
        cmos_pixel_packer u_packer (
            .core_clk   (core_clk),
            .rst_n_i    (rst_n_i),
            .cam_en_i   (cam_en[k]),
            .vsync_i    (cam_vsync_i[k]),
            .href_i     (cam_href_i[k]),
            .data_i     (cam_data_i[k]),
            .pix_data_o (pix_data[k]),
            .pix_de_o   (pix_de[k]),
            .pix_vs_o   (pix_vs[k])
        );
    end

    ////////////////////////////////////////////////////////////////////
    // output formatting
    ////////////////////////////////////////////////////////////////////
    video_out_select u_out_select (
        .core_clk   (core_clk),
        .rst_n_i    (rst_n_i),
        .src_sel_i  (src_sel_i),
        .pix_data_i (pix_data),
        .pix_de_i   (pix_de),
        .pix_vs_i   (pix_vs),
        .vs_o       (vs_o),
        .de_o       (de_o),
        .r_o        (r_o),
        .g_o        (g_o),
        .b_o        (b_o)
    );

    heartbeat_led u_heartbeat (
        .core_clk     (core_clk),
        .rst_n_i      (rst_n_i),
        .heart_beat_o (heart_beat_o)                     // alive indicator
    );

endmodule

// File: dv/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_o,    // core_clk for the DUT
    output logic rst_n_o   // synchronous, active low
);

    initial
    begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;                          // period of 10
    end

    // hold reset over two rising edges, release just after the second
    initial
    begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

// File: dv/tb_video_capture.sv
module tb_video_capture;

    logic                                                   core_clk;
    logic                                                   rst_n;
    logic [video_capture_pkg::NUM_CAMS-1:0]                 cam_vsync;
    logic [video_capture_pkg::NUM_CAMS-1:0]                 cam_href;
    video_capture_pkg::cam_byte_t [video_capture_pkg::NUM_CAMS-1:0] cam_data;
    video_capture_pkg::cam_idx_t                            src_sel;
    logic [video_capture_pkg::NUM_CAMS-1:0]                 cam_rstn;
    logic                                                   vs_o;
    logic                                                   de_o;
    video_capture_pkg::chan8_t                              r_o;
    video_capture_pkg::chan8_t                              g_o;
    video_capture_pkg::chan8_t                              b_o;
    logic                                                   heart_beat;

    logic [47:0]                 golden_mem [0:63];    // sel, flags, hi, lo, r, g, b
    int                          num_records;
    int                          cycle;                // rising edges since reset release
    logic                        vs_hist [0:1023];     // vsync driven per cycle
    int                          exp_cycle_q [$];      // cycle where de_o must rise
    video_capture_pkg::chan8_t   exp_r_q [$];
    video_capture_pkg::chan8_t   exp_g_q [$];
    video_capture_pkg::chan8_t   exp_b_q [$];
    int                          mismatch_cnt;
    int                          other_err_cnt;
    logic                        exp_hb;               // monitor scratch
    logic                        exp_vs;

    tb_clock_gen u_clk (
        .clk_o   (core_clk),
        .rst_n_o (rst_n)
    );

    video_capture_top UUT (
        .core_clk     (core_clk),
        .rst_n_i      (rst_n),
        .cam_vsync_i  (cam_vsync),
        .cam_href_i   (cam_href),
        .cam_data_i   (cam_data),
        .src_sel_i    (src_sel),
        .cam_rstn_o   (cam_rstn),
        .vs_o         (vs_o),
        .de_o         (de_o),
        .r_o          (r_o),
        .g_o          (g_o),
        .b_o          (b_o),
        .heart_beat_o (heart_beat)
    );

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic check_pixel(input video_capture_pkg::chan8_t actual,
                               input video_capture_pkg::chan8_t expected,
                               input string what);
        if (actual !== expected)
        begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s got %02h expected %02h", $time, what,
                     actual, expected);
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected)
        begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what,
                     actual, expected);
        end
    endtask

    // one cycle of camera inputs, driven just after the edge
    task automatic drive_cycle(input video_capture_pkg::cam_idx_t sel, input logic vs,
                               input logic href, input video_capture_pkg::cam_byte_t data,
                               input logic noise);
        int other;
        @(posedge core_clk);
        #1;
        other = (sel == 1'b0) ? 1 : 0;
        cam_vsync[sel]   = vs;
        cam_href[sel]    = href;
        cam_data[sel]    = data;
        cam_vsync[other] = 1'b0;
        cam_href[other]  = noise;                          // traffic on the hidden camera
        cam_data[other]  = video_capture_pkg::cam_byte_t'($urandom);
        vs_hist[cycle]   = vs;
    endtask

    task automatic idle_cycles(input video_capture_pkg::cam_idx_t sel, input int n);
        repeat (n) drive_cycle(sel, 1'b0, 1'b0, 8'h00, 1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // output monitor, sampled at the falling edge
    //////////////////////////////////////////////////////////////////////
    always @(posedge core_clk)
    begin
        if (!rst_n)
            cycle <= 0;
        else
            cycle <= cycle + 1;
    end

    always @(negedge core_clk)
    begin
        if (rst_n === 1'b1)
        begin
            exp_hb = ((cycle / 65) % 2) == 0;              // lit, flips every 65
            check_bit(heart_beat, exp_hb, "heart_beat_o");
            check_bit(cam_rstn[0], cycle >= 16, "cam_rstn_o[0]");
            check_bit(cam_rstn[1], cycle >= 32, "cam_rstn_o[1]");
            exp_vs = (cycle >= 3) ? vs_hist[cycle-3] : 1'b0;
            check_bit(vs_o, exp_vs, "vs_o");
            if (exp_cycle_q.size() > 0 && exp_cycle_q[0] == cycle)
            begin
                check_bit(de_o, 1'b1, "de_o");
                check_pixel(r_o, exp_r_q[0], "r_o");
                check_pixel(g_o, exp_g_q[0], "g_o");
                check_pixel(b_o, exp_b_q[0], "b_o");
                void'(exp_cycle_q.pop_front());
                void'(exp_r_q.pop_front());
                void'(exp_g_q.pop_front());
                void'(exp_b_q.pop_front());
            end
            else
            begin
                check_bit(de_o, 1'b0, "de_o");             // no stray or hidden pixels
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // watchdog
    //////////////////////////////////////////////////////////////////////
    initial
    begin
        int limit;
        wait (num_records > 0);
        limit = num_records * 4 + 2 * video_capture_pkg::POWER_STEP + 200;
        repeat (limit) @(posedge core_clk);
        other_err_cnt++;
        $display("watchdog expired after %0d cycles, the test did not finish", limit);
        $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_err_cnt);
        $display("STATUS: FAIL");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    initial
    begin
        video_capture_pkg::cam_idx_t   cur_sel;
        video_capture_pkg::cam_idx_t   rec_sel;
        logic [3:0]                    flags;
        cam_vsync     = '0;
        cam_href      = '0;
        cam_data      = '0;
        src_sel       = 1'b0;
        mismatch_cnt  = 0;
        other_err_cnt = 0;
        num_records   = 0;
        void'($urandom(32'h4464));                         // one seed for the run
        for (int i = 0; i < 1024; i++)
            vs_hist[i] = 1'b0;
        for (int i = 0; i < 64; i++)
            golden_mem[i] = 48'hF0_00_00_00_00_00;          // end marker
        $readmemh("dv/video_capture_golden.txt", golden_mem);
        while (num_records < 64 && golden_mem[num_records][47:44] != 4'hF)
            num_records++;
        if (num_records == 0)
        begin
            other_err_cnt++;
            $display("golden file holds no records");
        end

        wait (rst_n === 1'b1);
        // camera 0 shown while both are held
        repeat (12) drive_cycle(1'b0, 1'b0, 1'b1,
                                video_capture_pkg::cam_byte_t'($urandom), 1'b1);
        drive_cycle(1'b1, 1'b0, 1'b0, 8'h00, 1'b0);
        src_sel = 1'b1;                                    // camera 1 held until 32
        while (cycle < 28)
            drive_cycle(1'b1, 1'b0, 1'b1,
                        video_capture_pkg::cam_byte_t'($urandom), 1'b0);
        while (cycle < 40)
            idle_cycles(1'b1, 1);                          // past both releases

        cur_sel = src_sel;
        for (int i = 0; i < num_records; i++)
        begin
            rec_sel = golden_mem[i][44];
            flags   = golden_mem[i][43:40];
            if (i == 0 || rec_sel != cur_sel)
            begin
                idle_cycles(cur_sel, 4);                   // drain the old source
                drive_cycle(rec_sel, 1'b0, 1'b0, 8'h00, 1'b0);
                src_sel = rec_sel;
                cur_sel = rec_sel;
                idle_cycles(cur_sel, 2);
                drive_cycle(cur_sel, 1'b1, 1'b0, 8'h00, 1'b0); // frame start
                idle_cycles(cur_sel, 1);
            end
            drive_cycle(cur_sel, 1'b0, 1'b1, golden_mem[i][39:32], 1'b1); // high byte
            drive_cycle(cur_sel, 1'b0, 1'b1, golden_mem[i][31:24], 1'b1); // low byte
            exp_cycle_q.push_back(cycle + 3);
            exp_r_q.push_back(golden_mem[i][23:16]);
            exp_g_q.push_back(golden_mem[i][15:8]);
            exp_b_q.push_back(golden_mem[i][7:0]);
            if (flags == 4'h2)
                drive_cycle(cur_sel, 1'b0, 1'b1,
                            video_capture_pkg::cam_byte_t'($urandom), 1'b1); // odd byte
            if (flags != 4'h0)
                drive_cycle(cur_sel, 1'b0, 1'b0, 8'h00, 1'b1); // href low, line end
        end

        idle_cycles(cur_sel, 10);
        while (cycle < 150)
            idle_cycles(cur_sel, 1);                       // two heartbeat flips seen

        if (exp_cycle_q.size() != 0)
        begin
            other_err_cnt++;
            $display("%0d expected pixels never appeared on the output", exp_cycle_q.size());
        end
        $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_err_cnt);
        if (mismatch_cnt == 0 && other_err_cnt == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: dv/video_capture_golden.txt
// one record per line: sel _ flags _ hi _ lo _ r _ g _ b, all hex
// flags 0 line goes on, 1 line ends, 2 one odd byte then line ends
0_0_F8_00_00_00_F8
0_0_07_E0_00_FC_00
0_0_00_1F_F8_00_00
0_1_FF_FF_F8_FC_F8
0_0_12_34_A0_44_10
0_2_AB_CD_68_78_A8
0_0_5A_A5_28_54_58
0_1_81_42_10_28_80
0_0_3C_C3_18_98_38
0_2_96_69_48_CC_90
// camera 1 frame
1_0_0F_F0_80_FC_08
1_0_E7_7E_F0_EC_E0
1_0_24_8A_50_90_20
1_1_C9_B1_88_34_C8
1_0_6D_2E_70_A4_68
1_2_33_CC_60_78_30
1_0_7B_5F_F8_68_78
1_1_A0_09_48_00_A0
// back to camera 0
0_0_01_20_00_24_00
0_0_FE_01_08_C0_F8
0_0_55_AA_50_B4_50
0_2_4C_3D_E8_84_48
// camera 1 again
1_0_18_E3_18_1C_18
1_1_9F_7C_E0_EC_98
// end marker
F_0_00_00_00_00_00

// File: project.f
src/video_capture_pkg.sv
src/cam_power_seq.sv
src/cmos_pixel_packer.sv
src/video_out_select.sv
src/heartbeat_led.sv
src/video_capture_top.sv
dv/tb_clock_gen.sv
dv/tb_video_capture.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the video capture testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_video_capture \
    -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
